//--- include/axil_slv_config.svh
// ~~~~~~~~~~~~~~~~~~~~
// AXI-Lite simple target configuration
// bus widths and default target settings
// ~~~~~~~~~~~~~~~~~~~~

`ifndef AXIL_SLV_CONFIG_SVH
`define AXIL_SLV_CONFIG_SVH

// bus widths
`define AXIL_ADDR_WIDTH 32
`define AXIL_DATA_WIDTH 32

// default address window
// an end of zero leaves the window open at the top
`define AXIL_DEF_ADDR_S 32'h0000_0000
`define AXIL_DEF_ADDR_E 32'h0000_0000

// constant word returned on reads and expected on writes
`define AXIL_DEF_DATA 32'h0000_FFFF

// pending beats per channel
`define AXIL_DEF_MAX_TRANS 4

`endif

//--- source/axil_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// AXI-Lite protocol types
// ~~~~~~~~~~~~~~~~~~~~

`include "axil_slv_config.svh"

package axil_pkg;

    typedef logic [`AXIL_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0]   data_t;
    typedef logic [`AXIL_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [2:0]                    prot_t;

    // response codes as on the B and R channels
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // window test shared by both paths
    // hi of zero means no upper end
    function automatic logic in_window(
        input addr_t addr,
        input addr_t lo,
        input addr_t hi
    );
        return (addr >= lo) && ((hi == '0) || (addr < hi));
    endfunction

endpackage

//--- source/axil_slv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// AXI-Lite simple target internal states
// ~~~~~~~~~~~~~~~~~~~~

package axil_slv_pkg;

    // write pairing
    // idle until both heads are present
    // hold while the B queue has no room
    typedef enum logic [1:0] {
        WR_IDLE  = 2'd0,
        WR_JUDGE = 2'd1,
        WR_HOLD  = 2'd2
    } wr_state_e;

    // read path
    // full means the R queue holds every pending slot
    typedef enum logic {
        RD_IDLE = 1'b0,
        RD_FULL = 1'b1
    } rd_state_e;

endpackage

//--- source/axil_lite_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// AXI-Lite bus between the target top and its paths
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface axil_lite_if;
    import axil_pkg::*;

    // write address
    addr_t aw_addr;
    prot_t aw_prot;
    logic  aw_valid;
    logic  aw_ready;

    // write data
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  w_ready;

    // write response
    resp_e b_resp;
    logic  b_valid;
    logic  b_ready;

    // read address
    addr_t ar_addr;
    prot_t ar_prot;
    logic  ar_valid;
    logic  ar_ready;

    // read data
    data_t r_data;
    resp_e r_resp;
    logic  r_valid;
    logic  r_ready;

    modport wr_slave (
        input  aw_addr, aw_prot, aw_valid, w_data, w_strb, w_valid, b_ready,
        output aw_ready, w_ready, b_resp, b_valid
    );

    modport rd_slave (
        input  ar_addr, ar_prot, ar_valid, r_ready,
        output ar_ready, r_data, r_resp, r_valid
    );

    // manager side, driven from the plain top ports
    modport port (
        output aw_addr, aw_prot, aw_valid, w_data, w_strb, w_valid, b_ready,
        output ar_addr, ar_prot, ar_valid, r_ready,
        input  aw_ready, w_ready, b_resp, b_valid,
        input  ar_ready, r_data, r_resp, r_valid
    );

endinterface

//--- source/axil_pend_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// pending beat FIFO
// circular buffer with head shown combinationally
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axil_pend_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 4
) (
    input  logic             seq,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             pop,
    output logic [WIDTH-1:0] rd_data,
    output logic             full,
    output logic             empty
);
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge seq) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge seq) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- source/axil_slv_write.sv
// ~~~~~~~~~~~~~~~~~~~~
// AXI-Lite target write path
// pairs AW with W, judges the pair, queues B
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "axil_slv_config.svh"

module axil_slv_write #(
    parameter axil_pkg::addr_t ADDR_S    = `AXIL_DEF_ADDR_S,
    parameter axil_pkg::addr_t ADDR_E    = `AXIL_DEF_ADDR_E,
    parameter axil_pkg::data_t DATA      = `AXIL_DEF_DATA,
    parameter int unsigned     MAX_TRANS = `AXIL_DEF_MAX_TRANS
) (
    input logic           seq,
    input logic           rst,
    axil_lite_if.wr_slave bus
);
    import axil_pkg::*;
    import axil_slv_pkg::*;

    typedef struct packed {
        addr_t addr;
        prot_t prot;
    } aw_entry_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_entry_t;

    aw_entry_t                aw_in;
    aw_entry_t                aw_head;
    w_entry_t                 w_in;
    w_entry_t                 w_head;
    logic                     aw_full;
    logic                     aw_empty;
    logic                     w_full;
    logic                     w_empty;
    logic                     b_full;
    logic                     b_empty;
    logic                     pair_pop;
    resp_e                    judged;
    logic [$bits(resp_e)-1:0] b_head;
    wr_state_e                state;

    assign aw_in = '{addr: bus.aw_addr, prot: bus.aw_prot};
    assign w_in  = '{data: bus.w_data, strb: bus.w_strb};

    assign bus.aw_ready = !aw_full;
    assign bus.w_ready  = !w_full;
    assign bus.b_valid  = !b_empty;
    assign bus.b_resp   = resp_e'(b_head);

    // pairing decision, taken from the queue flags each cycle
    always_comb begin
        if (aw_empty || w_empty) begin
            state = WR_IDLE;
        end else if (b_full) begin
            state = WR_HOLD;
        end else begin
            state = WR_JUDGE;
        end
    end

    assign pair_pop = (state == WR_JUDGE);

    // strobes and prot ride along but do not change the answer
    assign judged = (in_window(aw_head.addr, ADDR_S, ADDR_E) && (w_head.data == DATA)) ?
                    RESP_OKAY : RESP_DECERR;

    axil_pend_fifo #(.WIDTH($bits(aw_entry_t)), .DEPTH(MAX_TRANS)) i_aw_fifo (
        .seq(seq), .rst(rst),
        .push(bus.aw_valid && bus.aw_ready), .wr_data(aw_in),
        .pop(pair_pop), .rd_data(aw_head),
        .full(aw_full), .empty(aw_empty)
    );

    axil_pend_fifo #(.WIDTH($bits(w_entry_t)), .DEPTH(MAX_TRANS)) i_w_fifo (
        .seq(seq), .rst(rst),
        .push(bus.w_valid && bus.w_ready), .wr_data(w_in),
        .pop(pair_pop), .rd_data(w_head),
        .full(w_full), .empty(w_empty)
    );

    axil_pend_fifo #(.WIDTH($bits(resp_e)), .DEPTH(MAX_TRANS)) i_b_fifo (
        .seq(seq), .rst(rst),
        .push(pair_pop), .wr_data(judged),
        .pop(bus.b_valid && bus.b_ready), .rd_data(b_head),
        .full(b_full), .empty(b_empty)
    );

endmodule

//--- source/axil_slv_read.sv
// ~~~~~~~~~~~~~~~~~~~~
// AXI-Lite target read path
// judges each AR and queues the R beat
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "axil_slv_config.svh"

module axil_slv_read #(
    parameter axil_pkg::addr_t ADDR_S    = `AXIL_DEF_ADDR_S,
    parameter axil_pkg::addr_t ADDR_E    = `AXIL_DEF_ADDR_E,
    parameter axil_pkg::data_t DATA      = `AXIL_DEF_DATA,
    parameter int unsigned     MAX_TRANS = `AXIL_DEF_MAX_TRANS
) (
    input logic           seq,
    input logic           rst,
    axil_lite_if.rd_slave bus
);
    import axil_pkg::*;
    import axil_slv_pkg::*;

    typedef struct packed {
        data_t data;
        resp_e resp;
    } r_entry_t;

    r_entry_t  r_in;
    r_entry_t  r_head;
    logic      r_full;
    logic      r_empty;
    rd_state_e state;

    // judged at the AR edge itself, so R is valid one cycle later
    always_comb begin
        if (in_window(bus.ar_addr, ADDR_S, ADDR_E)) begin
            r_in = '{data: DATA, resp: RESP_OKAY};
        end else begin
            r_in = '{data: '0, resp: RESP_DECERR};
        end
    end

    assign state = r_full ? RD_FULL : RD_IDLE;

    // stop taking addresses once every slot holds a response
    assign bus.ar_ready = (state != RD_FULL);
    assign bus.r_valid  = !r_empty;
    assign bus.r_data   = r_head.data;
    assign bus.r_resp   = r_head.resp;

    axil_pend_fifo #(.WIDTH($bits(r_entry_t)), .DEPTH(MAX_TRANS)) i_r_fifo (
        .seq(seq), .rst(rst),
        .push(bus.ar_valid && bus.ar_ready), .wr_data(r_in),
        .pop(bus.r_valid && bus.r_ready), .rd_data(r_head),
        .full(r_full), .empty(r_empty)
    );

endmodule

//--- source/axil_slv_simple.sv
// ~~~~~~~~~~~~~~~~~~~~
// AXI-Lite target with a fixed response
// plain bus ports around the write and read paths
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "axil_slv_config.svh"

module axil_slv_simple #(
    parameter axil_pkg::addr_t ADDR_S    = `AXIL_DEF_ADDR_S,
    parameter axil_pkg::addr_t ADDR_E    = `AXIL_DEF_ADDR_E,
    parameter axil_pkg::data_t DATA      = `AXIL_DEF_DATA,
    parameter int unsigned     MAX_TRANS = `AXIL_DEF_MAX_TRANS
) (
    input  logic            seq,
    input  logic            rst,
    input  axil_pkg::addr_t aw_addr,
    input  axil_pkg::prot_t aw_prot,
    input  logic            aw_valid,
    output logic            aw_ready,
    input  axil_pkg::data_t w_data,
    input  axil_pkg::strb_t w_strb,
    input  logic            w_valid,
    output logic            w_ready,
    output axil_pkg::resp_e b_resp,
    output logic            b_valid,
    input  logic            b_ready,
    input  axil_pkg::addr_t ar_addr,
    input  axil_pkg::prot_t ar_prot,
    input  logic            ar_valid,
    output logic            ar_ready,
    output axil_pkg::data_t r_data,
    output axil_pkg::resp_e r_resp,
    output logic            r_valid,
    input  logic            r_ready
);
    axil_lite_if bus ();

    // manager side of the bus, as in the port view
    assign bus.aw_addr  = aw_addr;
    assign bus.aw_prot  = aw_prot;
    assign bus.aw_valid = aw_valid;
    assign bus.w_data   = w_data;
    assign bus.w_strb   = w_strb;
    assign bus.w_valid  = w_valid;
    assign bus.b_ready  = b_ready;
    assign bus.ar_addr  = ar_addr;
    assign bus.ar_prot  = ar_prot;
    assign bus.ar_valid = ar_valid;
    assign bus.r_ready  = r_ready;

    assign aw_ready = bus.aw_ready;
    assign w_ready  = bus.w_ready;
    assign b_resp   = bus.b_resp;
    assign b_valid  = bus.b_valid;
    assign ar_ready = bus.ar_ready;
    assign r_data   = bus.r_data;
    assign r_resp   = bus.r_resp;
    assign r_valid  = bus.r_valid;

    axil_slv_write #(
        .ADDR_S(ADDR_S), .ADDR_E(ADDR_E), .DATA(DATA), .MAX_TRANS(MAX_TRANS)
    ) i_write (
        .seq(seq), .rst(rst), .bus(bus.wr_slave)
    );

    axil_slv_read #(
        .ADDR_S(ADDR_S), .ADDR_E(ADDR_E), .DATA(DATA), .MAX_TRANS(MAX_TRANS)
    ) i_read (
        .seq(seq), .rst(rst), .bus(bus.rd_slave)
    );

endmodule

//--- test/axil_slv_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// AXI-Lite target response checker
// predicts B and R beats from the address window rule
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "axil_slv_config.svh"

module axil_slv_checker #(
    parameter axil_pkg::addr_t ADDR_S = `AXIL_DEF_ADDR_S,
    parameter axil_pkg::addr_t ADDR_E = `AXIL_DEF_ADDR_E,
    parameter axil_pkg::data_t DATA   = `AXIL_DEF_DATA
) (
    input  logic            seq,
    input  logic            rst,
    input  axil_pkg::addr_t aw_addr,
    input  logic            aw_valid,
    input  logic            aw_ready,
    input  axil_pkg::data_t w_data,
    input  logic            w_valid,
    input  logic            w_ready,
    input  axil_pkg::resp_e b_resp,
    input  logic            b_valid,
    input  logic            b_ready,
    input  axil_pkg::addr_t ar_addr,
    input  logic            ar_valid,
    input  logic            ar_ready,
    input  axil_pkg::data_t r_data,
    input  axil_pkg::resp_e r_resp,
    input  logic            r_valid,
    input  logic            r_ready,
    output int              test_cnt,
    output int              fail_cnt
);
    import axil_pkg::*;

    // requests seen on the bus, and predicted answers in request order
    addr_t aw_q[$];
    data_t w_q[$];
    resp_e b_pred_q[$];
    resp_e r_pred_q[$];
    data_t r_data_q[$];
    // answers the stimulus table expects
    resp_e b_tab_q[$];
    resp_e r_tab_q[$];
    data_t r_tab_data_q[$];
    bit    after_reset = 1'b0;

    initial begin
        test_cnt = 0;
        fail_cnt = 0;
    end

    function automatic bit addr_hit(input addr_t a);
        bit below_end;
        // no upper end when the end address is zero
        below_end = (ADDR_E == '0) ? 1'b1 : (a < ADDR_E);
        return (a >= ADDR_S) && below_end;
    endfunction

    function automatic bit match_value(input string name, input logic [31:0] exp,
                                       input logic [31:0] got);
        if (exp !== got) begin
            $display("Fail %s exp %0h got %0h", name, exp, got);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic finish_test(input string what, input bit ok);
        test_cnt++;
        if (ok) begin
            $display("test %0d %s ok", test_cnt, what);
        end else begin
            fail_cnt++;
        end
    endtask

    task automatic expect_write(input resp_e resp);
        b_tab_q.push_back(resp);
    endtask

    task automatic expect_read(input resp_e resp, input data_t data);
        r_tab_q.push_back(resp);
        r_tab_data_q.push_back(data);
    endtask

    always @(posedge seq) begin
        resp_e exp_resp;
        data_t exp_data;
        addr_t a;
        data_t d;
        bit    ok;
        if (rst) begin
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                after_reset = 1'b0;
                ok = match_value("aw_ready", 1, aw_ready) & match_value("w_ready", 1, w_ready)
                   & match_value("ar_ready", 1, ar_ready) & match_value("b_valid", 0, b_valid)
                   & match_value("r_valid", 0, r_valid);
                finish_test("reset state", ok);
            end
            // responses before requests, so an early beat shows up as unexpected
            if (b_valid && b_ready) begin
                if (b_pred_q.size() == 0) begin
                    $display("a write response arrived with no write pending");
                    finish_test("write", 1'b0);
                end else begin
                    exp_resp = b_pred_q.pop_front();
                    ok = match_value("b_resp", exp_resp, b_resp);
                    if (b_tab_q.size() > 0 && b_tab_q.pop_front() !== exp_resp) begin
                        $display("the stimulus table and the window rule disagree on a write");
                        ok = 1'b0;
                    end
                    finish_test("write", ok);
                end
            end
            if (r_valid && r_ready) begin
                if (r_pred_q.size() == 0) begin
                    $display("a read response arrived with no read pending");
                    finish_test("read", 1'b0);
                end else begin
                    exp_resp = r_pred_q.pop_front();
                    exp_data = r_data_q.pop_front();
                    ok = match_value("r_resp", exp_resp, r_resp)
                       & match_value("r_data", exp_data, r_data);
                    if (r_tab_q.size() > 0) begin
                        if (r_tab_q.pop_front() !== exp_resp
                                || r_tab_data_q.pop_front() !== exp_data) begin
                            $display("the stimulus table and the window rule disagree on a read");
                            ok = 1'b0;
                        end
                    end
                    finish_test("read", ok);
                end
            end
            if (aw_valid && aw_ready) begin
                aw_q.push_back(aw_addr);
            end
            if (w_valid && w_ready) begin
                w_q.push_back(w_data);
            end
            // AW and W pair up strictly in arrival order
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                a = aw_q.pop_front();
                d = w_q.pop_front();
                b_pred_q.push_back((addr_hit(a) && d == DATA) ? RESP_OKAY : RESP_DECERR);
            end
            if (ar_valid && ar_ready) begin
                r_pred_q.push_back(addr_hit(ar_addr) ? RESP_OKAY : RESP_DECERR);
                r_data_q.push_back(addr_hit(ar_addr) ? DATA : '0);
            end
        end
    end

endmodule

//--- test/axil_slv_properties.sv
// ~~~~~~~~~~~~~~~~~~~~
// AXI-Lite target bus properties
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "axil_slv_config.svh"

module axil_slv_properties #(
    parameter int unsigned MAX_TRANS = `AXIL_DEF_MAX_TRANS
) (
    input logic            seq,
    input logic            rst,
    input logic            ar_valid,
    input logic            ar_ready,
    input axil_pkg::resp_e b_resp,
    input logic            b_valid,
    input logic            b_ready,
    input axil_pkg::data_t r_data,
    input axil_pkg::resp_e r_resp,
    input logic            r_valid,
    input logic            r_ready
);
    import axil_slv_pkg::*;

    int        pending;
    rd_state_e seen_state;

    // reads accepted but not yet answered
    always_ff @(posedge seq) begin
        if (rst) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(ar_valid && ar_ready) - int'(r_valid && r_ready);
        end
    end

    assign seen_state = (pending == MAX_TRANS) ? RD_FULL : RD_IDLE;

    a_reset_valid: assert property (@(posedge seq) rst |=> (!b_valid && !r_valid))
        else $error("response valid high during or right after reset");

    a_b_stable: assert property (@(posedge seq) disable iff (rst)
        (b_valid && !b_ready) |=> (b_valid && $stable(b_resp)))
        else $error("B channel changed before its transfer");

    a_r_stable: assert property (@(posedge seq) disable iff (rst)
        (r_valid && !r_ready) |=> (r_valid && $stable(r_data) && $stable(r_resp)))
        else $error("R channel changed before its transfer");

    a_ar_full: assert property (@(posedge seq) disable iff (rst)
        !ar_ready |-> (seen_state == RD_FULL))
        else $error("ar_ready low with fewer reads pending than the queue holds");

endmodule

bind axil_slv_simple axil_slv_properties #(.MAX_TRANS(MAX_TRANS)) i_properties (
    .seq(seq), .rst(rst), .ar_valid(ar_valid), .ar_ready(ar_ready),
    .b_resp(b_resp), .b_valid(b_valid), .b_ready(b_ready),
    .r_data(r_data), .r_resp(r_resp), .r_valid(r_valid), .r_ready(r_ready)
);

//--- test/tb_axil_slv_simple.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the fixed response AXI-Lite target
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_axil_slv_simple;
    import axil_pkg::*;

    typedef enum bit {KIND_READ, KIND_WRITE} kind_e;

    typedef struct {
        kind_e kind;
        addr_t addr;
        data_t data;
        strb_t strb;
        int    skew;    // -1 W leads AW, 1 W trails AW
        int    stall;   // cycles with the response ready held low
        bit    burst;   // issued without waiting for its answer
        resp_e exp_resp;
        data_t exp_data;
    } row_t;

    localparam addr_t WIN_S = 32'h0000_1000;
    localparam addr_t WIN_E = 32'h0000_2000;
    localparam data_t WORD  = 32'h0000_FFFF;

    logic  seq = 1'b0;
    logic  rst;
    addr_t aw_addr;
    prot_t aw_prot;
    logic  aw_valid;
    logic  aw_ready;
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  w_ready;
    resp_e b_resp;
    logic  b_valid;
    logic  b_ready;
    addr_t ar_addr;
    prot_t ar_prot;
    logic  ar_valid;
    logic  ar_ready;
    data_t r_data;
    resp_e r_resp;
    logic  r_valid;
    logic  r_ready;
    int    test_cnt;
    int    fail_cnt;
    row_t  rows[$];
    int    want;
    int    limit = 0;

    axil_slv_simple #(
        .ADDR_S(WIN_S), .ADDR_E(WIN_E), .DATA(WORD), .MAX_TRANS(4)
    ) i_axil_slv_simple (.*);

    axil_slv_checker #(.ADDR_S(WIN_S), .ADDR_E(WIN_E), .DATA(WORD)) i_checker (.*);

    always #10 seq = ~seq;

    task automatic add_row(input kind_e kind, input addr_t addr, input data_t data,
                           input strb_t strb, input int skew, input int stall, input bit burst,
                           input resp_e exp_resp, input data_t exp_data);
        rows.push_back('{kind, addr, data, strb, skew, stall, burst, exp_resp, exp_data});
    endtask

    // ready outputs depend only on queue state, so sampling at the falling edge is safe
    task automatic run_write(input row_t r);
        int n;
        bit aw_done;
        bit w_done;
        n = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        aw_addr = r.addr;
        w_data = r.data;
        w_strb = r.strb;
        if (r.stall > 0) begin
            b_ready = 1'b0;
        end
        while (!(aw_done && w_done)) begin
            aw_valid = !aw_done && (r.skew >= 0 || n > 0);
            w_valid = !w_done && (r.skew <= 0 || n > 0);
            if (aw_valid && aw_ready) begin
                aw_done = 1'b1;
            end
            if (w_valid && w_ready) begin
                w_done = 1'b1;
            end
            @(negedge seq);
            n++;
        end
        aw_valid = 1'b0;
        w_valid = 1'b0;
        repeat (r.stall) @(negedge seq);
        b_ready = 1'b1;
    endtask

    task automatic run_read(input row_t r);
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        ar_addr = r.addr;
        while (!done) begin
            ar_valid = 1'b1;
            if (ar_ready) begin
                done = 1'b1;
            end else if (r.burst && n >= r.stall) begin
                // queue is full, let the responses drain
                r_ready = 1'b1;
            end
            @(negedge seq);
            n++;
        end
        ar_valid = 1'b0;
        if (!r.burst && r.stall > 0) begin
            r_ready = 1'b0;
            repeat (r.stall) @(negedge seq);
            r_ready = 1'b1;
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (limit == 0 || cycles < limit) begin
            @(posedge seq);
            cycles++;
        end
        $display("run timed out after %0d cycles, %0d of %0d tests done", cycles, test_cnt, want);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : driver
        int max_stall;
        bit prev_burst;
        rst = 1'b1;
        aw_addr = '0;
        aw_prot = '0;
        aw_valid = 1'b0;
        w_data = '0;
        w_strb = '0;
        w_valid = 1'b0;
        b_ready = 1'b1;
        ar_addr = '0;
        ar_prot = '0;
        ar_valid = 1'b0;
        r_ready = 1'b1;
        add_row(KIND_READ, 32'h0000_1000, '0, 4'h0, 0, 0, 0, RESP_OKAY, WORD);
        add_row(KIND_READ, 32'h0000_1FFC, '0, 4'h0, 0, 0, 0, RESP_OKAY, WORD);
        add_row(KIND_READ, 32'h0000_0FFC, '0, 4'h0, 0, 0, 0, RESP_DECERR, '0);
        add_row(KIND_READ, 32'h0000_2000, '0, 4'h0, 0, 0, 0, RESP_DECERR, '0);
        add_row(KIND_WRITE, 32'h0000_1004, WORD, 4'hF, 0, 0, 0, RESP_OKAY, '0);
        add_row(KIND_WRITE, 32'h0000_1004, 32'h1234_5678, 4'hF, 0, 0, 0, RESP_DECERR, '0);
        add_row(KIND_WRITE, 32'h0000_3000, WORD, 4'hF, 0, 0, 0, RESP_DECERR, '0);
        // three skewed writes overlapping, answers must keep request order
        add_row(KIND_WRITE, 32'h0000_1008, WORD, 4'hF, -1, 0, 1, RESP_OKAY, '0);
        add_row(KIND_WRITE, 32'h0000_1008, WORD, 4'h1, 1, 0, 1, RESP_OKAY, '0);
        add_row(KIND_WRITE, 32'h0000_100C, '0, 4'hF, 1, 0, 0, RESP_DECERR, '0);
        add_row(KIND_WRITE, 32'h0000_1010, WORD, 4'hF, 0, 5, 0, RESP_OKAY, '0);
        add_row(KIND_WRITE, 32'h0000_1014, WORD, 4'hF, 0, 0, 0, RESP_OKAY, '0);
        add_row(KIND_READ, 32'h0000_1800, '0, 4'h0, 0, 3, 0, RESP_OKAY, WORD);
        // six reads back to back against a stalled R channel
        add_row(KIND_READ, 32'h0000_1000, '0, 4'h0, 0, 3, 1, RESP_OKAY, WORD);
        add_row(KIND_READ, 32'h0000_0000, '0, 4'h0, 0, 3, 1, RESP_DECERR, '0);
        add_row(KIND_READ, 32'h0000_1004, '0, 4'h0, 0, 3, 1, RESP_OKAY, WORD);
        add_row(KIND_READ, 32'h0000_2004, '0, 4'h0, 0, 3, 1, RESP_DECERR, '0);
        add_row(KIND_READ, 32'h0000_1FFC, '0, 4'h0, 0, 3, 1, RESP_OKAY, WORD);
        add_row(KIND_READ, 32'h0000_1008, '0, 4'h0, 0, 3, 1, RESP_OKAY, WORD);
        max_stall = 0;
        foreach (rows[i]) begin
            if (rows[i].stall > max_stall) begin
                max_stall = rows[i].stall;
            end
        end
        want = 1;
        limit = rows.size() * (max_stall + 12) + 5;
        repeat (5) @(negedge seq);
        rst = 1'b0;
        prev_burst = 1'b0;
        foreach (rows[i]) begin
            if (rows[i].kind == KIND_READ && rows[i].burst && !prev_burst) begin
                r_ready = 1'b0;
            end
            if (rows[i].kind == KIND_WRITE) begin
                i_checker.expect_write(rows[i].exp_resp);
                run_write(rows[i]);
            end else begin
                i_checker.expect_read(rows[i].exp_resp, rows[i].exp_data);
                run_read(rows[i]);
            end
            want++;
            while (!rows[i].burst && test_cnt < want) @(negedge seq);
            prev_burst = rows[i].burst;
        end
        r_ready = 1'b1;
        while (test_cnt < want) @(negedge seq);
        repeat (2) @(negedge seq);
        if (test_cnt != want) begin
            $display("expected %0d responses but saw %0d", want, test_cnt);
        end
        $display("tests %0d, passed %0d, failed %0d", test_cnt, test_cnt - fail_cnt, fail_cnt);
        if (fail_cnt == 0 && test_cnt == want) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
source/axil_pkg.sv
source/axil_slv_pkg.sv
source/axil_lite_if.sv
source/axil_pend_fifo.sv
source/axil_slv_write.sv
source/axil_slv_read.sv
source/axil_slv_simple.sv
test/axil_slv_checker.sv
test/axil_slv_properties.sv
test/tb_axil_slv_simple.sv

//--- Bender.yml
package:
  name: axil_slv_simple

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/axil_pkg.sv
      - source/axil_slv_pkg.sv
      - source/axil_lite_if.sv
      - source/axil_pend_fifo.sv
      - source/axil_slv_write.sv
      - source/axil_slv_read.sv
      - source/axil_slv_simple.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/axil_slv_checker.sv
      - test/axil_slv_properties.sv
      - test/tb_axil_slv_simple.sv
